// File: hw/agusec_pkg.sv
package agusec_pkg;

  // field widths of a compressed pointer
  localparam int unsigned ptr_w  = 65;
  localparam int unsigned exp_w  = 5;
  localparam int unsigned bnd_w  = 7;
  localparam int unsigned addr_w = 40;

  // field positions, stacked upward from the address
  localparam int unsigned ptr_addr_lsb   = 4;
  localparam int unsigned ptr_on_low_bit = ptr_addr_lsb + addr_w;   // 44
  localparam int unsigned ptr_low_lsb    = ptr_on_low_bit + 1;      // 51:45
  localparam int unsigned ptr_hi_lsb     = ptr_low_lsb + bnd_w;     // 58:52
  localparam int unsigned ptr_exp_lsb    = ptr_hi_lsb + bnd_w;      // 63:59

  typedef struct packed {
    logic [ptr_w-ptr_exp_lsb-exp_w-1:0] spare_hi;
    logic [exp_w-1:0]                   exp;
    logic [bnd_w-1:0]                   hi;
    logic [bnd_w-1:0]                   low;
    logic                               on_low;
    logic [addr_w-1:0]                  address;
    logic [ptr_addr_lsb-1:0]            spare_lo;
  } agusec_ptr_s;

  // same 65-bit word, seen raw or split into fields
  typedef union packed {
    logic [ptr_w-1:0] raw;
    agusec_ptr_s      f;
  } agusec_ptr_u;

  // carry out of a + b + cin
  // a <= b is carry_out(~a, b, 1), a < b is carry_out(~a, b, 0)
  // narrower operands: pad a with 0 and the inverted side with 1
  function automatic logic carry_out(input logic [7:0] a,
                                     input logic [7:0] b,
                                     input logic       cin);
    logic [8:0] sum;
    sum = {1'b0, a} + {1'b0, b} + {8'd0, cin};
    return sum[8];
  endfunction

  function automatic logic redand8(input logic [7:0] din);
    return &din;
  endfunction

  function automatic logic redor8(input logic [7:0] din);
    return |din;
  endfunction

endpackage

// File: hw/agusec_shift8.sv
module agusec_shift8 import agusec_pkg::*; (
  input  logic [exp_w-1:0]  exp,
  input  logic [addr_w-1:0] addr,
  output logic [7:0]        bits
);

  logic [14:0] window; // byte at exp[4:3] plus the seven bits above it

  // coarse step by byte lane
  always_comb
  begin
    case (exp[4:3])
      2'd0: window = addr[14:0];
      2'd1: window = addr[22:8];
      2'd2: window = addr[30:16];
      default: window = addr[38:24];
    endcase
  end

  // fine step within the 15-bit window
  always_comb
  begin
    case (exp[2:0])
      3'd0: bits = window[7:0];
      3'd1: bits = window[8:1];
      3'd2: bits = window[9:2];
      3'd3: bits = window[10:3];
      3'd4: bits = window[11:4];
      3'd5: bits = window[12:5];
      3'd6: bits = window[13:6];
      default: bits = window[14:7];
    endcase
  end

endmodule

// File: hw/agusec_check_upper.sv
module agusec_check_upper import agusec_pkg::*; #(
  parameter bit AGU = 1'b0
) (
  input  agusec_ptr_u       ptr,
  input  logic [addr_w-1:0] a,
  input  logic [addr_w-1:0] b,
  output logic [2:0]        pos_ack,
  output logic [2:0]        neg_ack,
  output logic [1:0]        pos_flip,
  output logic [1:0]        neg_flip,
  output logic              nhi_less
);

  logic [exp_w-1:0] exp;
  logic [addr_w:0]  or_v;
  logic [addr_w:0]  xor_v;
  logic [addr_w:0]  and_v;
  logic [7:0]       fine_msk;
  logic [7:0]       msk_edge;
  logic             on_low;
  logic             on_hi;
  logic             wrap;
  logic             max;
  logic             open_hi;
  logic             top;

  // per-lane window tests
  logic [3:0] pos0, pos2, pos3;
  logic [3:0] neg0, neg1, neg2, neg3;
  logic [3:0] xpos0, xpos2, xpos3;
  logic [3:0] xneg0, xneg1, xneg2, xneg3;

  logic do_pos, do_pos2, do_pos3;
  logic do_neg, do_neg1, do_neg2, do_neg3;

  assign exp    = ptr.f.exp;
  assign on_low = ptr.f.on_low;
  assign on_hi  = ~on_low;
  assign max    = (exp == 5'h1f);

  // hi mantissa of all ones is an open top bound, except in the AGU variant
  assign open_hi = ~AGU & (ptr.f.hi == 7'h7f);
  assign top     = max | open_hi;

  // operand vectors, bit 40 models the bit past the address
  assign or_v  = {1'b0, a | b};
  assign xor_v = {1'b1, a ^ b};
  assign and_v = {1'b1, a & b};

  // hi >= low, padded compare on 7 bits
  assign nhi_less = carry_out({1'b0, ptr.f.hi}, {1'b1, ~ptr.f.low}, 1'b1);
  assign wrap     = ~nhi_less; // bounds wrap around the window

  genvar i;
  for (i = 0; i < 8; i++)
  begin : g_msk
    assign fine_msk[i] = (3'(i) > exp[2:0]); // bits above the fine shift
  end
  assign msk_edge = {1'b0, fine_msk[7:1]} & ~fine_msk; // one-hot at exp[2:0]

  genvar p;
  for (p = 0; p < 4; p++)
  begin : g_lane
    logic sel;   // lane holds the exponent
    logic above; // lane lies wholly above the exponent byte

    assign sel   = (exp[4:3] == 2'(p));
    assign above = (2'(p) > exp[4:3]);

    // whole lanes above the window
    assign pos0[p] = ~above | ~redor8(or_v[p*8+8 +: 8]);
    assign pos2[p] = ~above | ~redor8(or_v[p*8+9 +: 8]);
    assign neg0[p] = ~above | redand8(xor_v[p*8+8 +: 8]);
    assign neg1[p] = ~above | redand8(and_v[p*8+8 +: 8]);
    assign neg2[p] = ~above | redand8(xor_v[p*8+9 +: 8]);

    // clean-operand tests in the exponent lane
    assign pos3[p] = ~sel | ~redor8(or_v[p*8+9 +: 8]);
    assign neg3[p] = ~sel | redand8(and_v[p*8+9 +: 8]);

    // exponent lane, masked by the fine shift
    assign xpos0[p] = ~sel | ~redor8(or_v[p*8+8 +: 8] & fine_msk);
    assign xpos2[p] = ~sel | (~redor8(or_v[p*8+9 +: 8] & fine_msk) &
                              ~redor8(and_v[p*8+9 +: 8] & msk_edge));
    assign xpos3[p] = ~sel | ~redor8(or_v[p*8+1 +: 8] & fine_msk);
    assign xneg0[p] = ~sel | redand8(xor_v[p*8+8 +: 8] | ~fine_msk);
    assign xneg1[p] = ~sel | redand8(and_v[p*8+8 +: 8] | ~fine_msk);
    assign xneg2[p] = ~sel | (redand8(xor_v[p*8+9 +: 8] | ~fine_msk) &
                              ~redor8(and_v[p*8+9 +: 8] & msk_edge));
    assign xneg3[p] = ~sel | redand8(and_v[p*8+1 +: 8] | ~fine_msk);
  end

  assign do_pos  = redand8({pos0, xpos0});
  assign do_pos2 = redand8({pos2, xpos2});
  assign do_pos3 = do_pos & redand8({pos3, xpos3});
  assign do_neg  = redand8({neg0, xneg0});
  assign do_neg1 = redand8({neg1, xneg1});
  assign do_neg2 = redand8({neg2, xneg2});
  assign do_neg3 = do_neg1 & redand8({neg3, xneg3}); // both operands sign-extended

  assign pos_ack[0] = (do_pos & ~(~wrap & on_hi)) | (do_pos2 & on_low & wrap) | top;
  assign pos_ack[1] = (do_pos & on_low & wrap) | top; // carry in set
  assign pos_ack[2] = do_pos3 | top;

  assign neg_ack[0] = do_neg & on_hi & wrap;
  assign neg_ack[1] = (do_neg & ~(~wrap & on_hi)) | ((do_neg2 | do_neg1) & on_hi & wrap);
  assign neg_ack[2] = do_neg3 | max;

  // pos side needs on_low, neg side on_hi, so never both
  assign pos_flip[0] = do_pos2 & ~do_pos & on_low & ~top;
  assign pos_flip[1] = do_pos & on_low & ~top;
  assign neg_flip[0] = do_neg & on_hi & ~max;
  assign neg_flip[1] = (do_neg2 | do_neg1) & ~do_neg & on_hi & ~max;

endmodule

// File: hw/agusec_range.sv
module agusec_range import agusec_pkg::*; (
  input  agusec_ptr_u ptr,
  input  logic        cin_secq,
  input  logic        diff,
  output logic        cout_secq
);

  logic [7:0] low_ext;
  logic [7:0] high_ext;
  logic [7:0] bits;
  logic       low_ok;
  logic       high_ok;
  logic       low_skip;
  logic       high_skip;

  // bounds widened to the 8-bit window
  assign low_ext  = {ptr.f.low, 1'b0};
  assign high_ext = {ptr.f.hi, 1'b1};

  agusec_shift8 u_shift (
    .exp  (ptr.f.exp),
    .addr (ptr.f.address),
    .bits (bits)
  );

  assign low_ok  = carry_out(~low_ext, bits, 1'b1);  // low_ext <= bits
  assign high_ok = carry_out(high_ext, ~bits, 1'b1); // bits <= high_ext

  // on_low picks which side of the window is trusted
  assign low_skip  = diff & ~ptr.f.on_low;
  assign high_skip = diff & ptr.f.on_low;

  assign cout_secq = cin_secq & (low_ok | low_skip) & (high_ok | high_skip);

endmodule

// File: hw/agusec_unit.sv
module agusec_unit import agusec_pkg::*; #(
  parameter bit AGU = 1'b0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  logic [ptr_w-1:0]  ptr,
  input  logic [addr_w-1:0] op_a,
  input  logic [addr_w-1:0] op_b,
  input  logic              cin_secq,
  output logic              out_valid,
  output logic              sec_ok,
  output logic [2:0]        pos_ack,
  output logic [2:0]        neg_ack,
  output logic [1:0]        pos_flip,
  output logic [1:0]        neg_flip
);

  agusec_ptr_u ptr_u;
  logic [2:0]  pos_ack_c;
  logic [2:0]  neg_ack_c;
  logic [1:0]  pos_flip_c;
  logic [1:0]  neg_flip_c;
  logic        nhi_less;
  logic        sec_ok_c;

  assign ptr_u.raw = ptr;

  agusec_check_upper #(
    .AGU (AGU)
  ) u_check (
    .ptr      (ptr_u),
    .a        (op_a),
    .b        (op_b),
    .pos_ack  (pos_ack_c),
    .neg_ack  (neg_ack_c),
    .pos_flip (pos_flip_c),
    .neg_flip (neg_flip_c),
    .nhi_less (nhi_less)
  );

  agusec_range u_range (
    .ptr       (ptr_u),
    .cin_secq  (cin_secq),
    .diff      (nhi_less),
    .cout_secq (sec_ok_c)
  );

  // results load only on a strobe and hold otherwise
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
      sec_ok    <= 1'b0;
      pos_ack   <= '0;
      neg_ack   <= '0;
      pos_flip  <= '0;
      neg_flip  <= '0;
    end
    else
    begin
      out_valid <= in_valid; // one-cycle pulse per item
      if (in_valid)
      begin
        sec_ok   <= sec_ok_c;
        pos_ack  <= pos_ack_c;
        neg_ack  <= neg_ack_c;
        pos_flip <= pos_flip_c;
        neg_flip <= neg_flip_c;
      end
    end
  end

endmodule

// File: dv/agusec_sva.sv
module agusec_sva (
  input logic       clk,
  input logic       arst_n,
  input logic       in_valid,
  input logic       out_valid,
  input logic [1:0] pos_flip,
  input logic [1:0] neg_flip
);
  timeunit 1ns;
  timeprecision 1ps;

  // a reset cycle leaves no result behind
  a_reset_quiet: assert property (@(posedge clk) !arst_n |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |=> out_valid)
    else $error("out_valid missing one cycle after in_valid");

  a_valid_drops: assert property (@(posedge clk) disable iff (!arst_n)
    !in_valid |=> !out_valid)
    else $error("out_valid high without in_valid the cycle before");

  a_flip_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !((pos_flip != 2'b00) && (neg_flip != 2'b00)))
    else $error("pos_flip and neg_flip both nonzero");

endmodule

bind agusec_unit agusec_sva u_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .pos_flip  (pos_flip),
  .neg_flip  (neg_flip)
);

// File: dv/agusec_tb.sv
module agusec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int single_vecs = 44; // range 25, on_low 8, max exp 5, clean 6
  localparam int stream_vecs = 50;
  localparam int limit_ns    = (4 * single_vecs + stream_vecs + 2 + 20 + 5) * 20;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic [64:0] ptr;
  logic [39:0] op_a;
  logic [39:0] op_b;
  logic        cin_secq;
  logic        out_valid;
  logic        sec_ok;
  logic [2:0]  pos_ack;
  logic [2:0]  neg_ack;
  logic [1:0]  pos_flip;
  logic [1:0]  neg_flip;
  int          errors;
  int          checks;
  int          seed;

  agusec_unit #(
    .AGU (1'b0)
  ) u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .ptr       (ptr),
    .op_a      (op_a),
    .op_b      (op_b),
    .cin_secq  (cin_secq),
    .out_valid (out_valid),
    .sec_ok    (sec_ok),
    .pos_ack   (pos_ack),
    .neg_ack   (neg_ack),
    .pos_flip  (pos_flip),
    .neg_flip  (neg_flip)
  );

  always #10 clk = ~clk;

  // spare bit, exp, hi, low, on_low, address, spare nibble
  function automatic logic [64:0] make_ptr(input logic [4:0] e, input logic [6:0] hi,
                                           input logic [6:0] lo, input logic ol,
                                           input logic [39:0] addr);
    return {1'b0, e, hi, lo, ol, addr, 4'h0};
  endfunction

  function automatic logic [39:0] rand40();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[39:0];
  endfunction

  // put bits at the exponent position, noise elsewhere
  function automatic logic [39:0] place_bits(input logic [7:0] bits, input logic [4:0] e,
                                             input logic [39:0] noise);
    logic [47:0] msk;
    logic [47:0] wide;
    msk  = 48'hff << e;
    wide = ({8'h00, noise} & ~msk) | ({40'h0, bits} << e);
    return wide[39:0];
  endfunction

  // range rule, bounds against address[exp +: 8]
  function automatic logic range_model(input logic [64:0] p, input logic cin);
    logic [47:0] wide;
    logic [7:0]  bits;
    logic [6:0]  lo;
    logic [6:0]  hi;
    logic        diff;
    logic        low_pass;
    logic        high_pass;
    wide      = {8'h00, p[43:4]} >> p[63:59];
    bits      = wide[7:0];
    lo        = p[51:45];
    hi        = p[58:52];
    diff      = (hi >= lo);
    low_pass  = ({lo, 1'b0} <= bits) || (diff && !p[44]);
    high_pass = (bits <= {hi, 1'b1}) || (diff && p[44]);
    return cin && low_pass && high_pass;
  endfunction

  task automatic report_mismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] want);
    errors++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
  endtask

  // one item, then wait for its out_valid
  task automatic apply_vec(input logic [64:0] p, input logic [39:0] a, input logic [39:0] b,
                           input logic cin);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    ptr      = p;
    op_a     = a;
    op_b     = b;
    cin_secq = cin;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    @(negedge clk);
    while (out_valid !== 1'b1 && waited < 4)
    begin
      @(negedge clk);
      waited++;
    end
    if (out_valid !== 1'b1)
    begin
      errors++;
      $display("out_valid never came for the item driven before %0t ns", $time);
    end
  endtask

  task automatic check_sec(input logic want);
    checks++;
    if (sec_ok !== want)
      report_mismatch("sec_ok", {15'h0, sec_ok}, {15'h0, want});
  endtask

  task automatic check_reset_state();
    checks++;
    if ({out_valid, sec_ok} !== 2'b00)
      report_mismatch("out_valid/sec_ok in reset", {14'h0, out_valid, sec_ok}, 16'h0);
    if ({pos_ack, neg_ack, pos_flip, neg_flip} !== 10'h0)
      report_mismatch("acks/flips in reset", {6'h0, pos_ack, neg_ack, pos_flip, neg_flip}, 16'h0);
  endtask

  task automatic test_range();
    logic [4:0]  e;
    logic [7:0]  bits;
    logic [64:0] p;
    int          i;
    int          k;
    for (i = 0; i < 4; i++)
    begin
      e = 5'(i * 9); // 0, 9, 18, 27
      for (k = 0; k < 6; k++)
      begin
        // low edge 0x42 with on_low set, high edge 0xb5 with on_low clear
        bits = (k < 3) ? 8'h41 + 8'(k) : 8'hb4 + 8'(k - 3);
        p    = make_ptr(e, 7'h5a, 7'h21, k < 3, place_bits(bits, e, rand40()));
        apply_vec(p, rand40(), rand40(), 1'b1);
        check_sec(range_model(p, 1'b1));
      end
    end
    p = make_ptr(5'd4, 7'h5a, 7'h21, 1'b0, place_bits(8'h80, 5'd4, rand40()));
    apply_vec(p, rand40(), rand40(), 1'b0);
    check_sec(1'b0); // chain input low
  endtask

  task automatic test_on_low();
    logic [64:0] p;
    logic [6:0]  lo;
    logic [6:0]  hi;
    int          j;
    for (j = 0; j < 8; j++)
    begin
      lo = j[0] ? 7'h40 : 7'h10; // j[0] gives hi < low
      hi = j[0] ? 7'h18 : 7'h30;
      p  = make_ptr(5'd12, hi, lo, j[1], place_bits(j[2] ? 8'hf0 : 8'h04, 5'd12, rand40()));
      apply_vec(p, '0, '0, 1'b1);
      check_sec(range_model(p, 1'b1));
    end
  endtask

  task automatic test_max_exp();
    logic [64:0] p;
    int          j;
    for (j = 0; j < 5; j++)
    begin
      p = make_ptr(5'd31, 7'($random(seed)), 7'($random(seed)), 1'($random(seed)), rand40());
      apply_vec(p, rand40(), rand40(), 1'b1);
      checks++;
      if (pos_ack !== 3'b111)
        report_mismatch("pos_ack at exp 31", {13'h0, pos_ack}, 16'h7);
      if (neg_ack[2] !== 1'b1)
        report_mismatch("neg_ack[2] at exp 31", {15'h0, neg_ack[2]}, 16'h1);
      if ({pos_flip, neg_flip} !== 4'h0)
        report_mismatch("flips at exp 31", {12'h0, pos_flip, neg_flip}, 16'h0);
      check_sec(range_model(p, 1'b1));
    end
  endtask

  task automatic test_clean();
    logic [64:0] p;
    logic [4:0]  e;
    int          j;
    for (j = 0; j < 3; j++)
    begin
      e = (j == 0) ? 5'd0 : (j == 1) ? 5'd11 : 5'd23;
      p = make_ptr(e, 7'($random(seed)), 7'($random(seed)), 1'($random(seed)), rand40());
      apply_vec(p, '0, '0, 1'b1);
      checks++;
      if (pos_ack[2] !== 1'b1)
        report_mismatch("pos_ack[2] with zero operands", {15'h0, pos_ack[2]}, 16'h1);
      apply_vec(p, '1, '1, 1'b1);
      checks++;
      if (neg_ack[2] !== 1'b1)
        report_mismatch("neg_ack[2] with all-ones operands", {15'h0, neg_ack[2]}, 16'h1);
    end
  endtask

  // item i is driven in cycle i and read back in cycle i + 1
  task automatic test_stream();
    logic [95:0] r;
    logic        want[stream_vecs];
    logic        cin;
    int          i;
    for (i = 0; i <= stream_vecs; i++)
    begin
      @(posedge clk);
      #1;
      if (i < stream_vecs)
      begin
        r        = {$random(seed), $random(seed), $random(seed)};
        cin      = (($random(seed) & 7) != 0);
        want[i]  = range_model(r[64:0], cin);
        in_valid = 1'b1;
        ptr      = r[64:0];
        op_a     = rand40();
        op_b     = rand40();
        cin_secq = cin;
      end
      else
        in_valid = 1'b0;
      @(negedge clk);
      if (i > 0)
      begin
        checks++;
        if (out_valid !== 1'b1)
        begin
          errors++;
          $display("out_valid missing for stream item %0d at %0t ns", i - 1, $time);
        end
        if (sec_ok !== want[i-1])
          report_mismatch("stream sec_ok", {15'h0, sec_ok}, {15'h0, want[i-1]});
        if (pos_flip != 2'b00 && neg_flip != 2'b00)
        begin
          errors++;
          $display("pos_flip and neg_flip both nonzero for stream item %0d", i - 1);
        end
      end
    end
    @(negedge clk);
    if (out_valid !== 1'b0)
    begin
      errors++;
      $display("out_valid stayed high after the last stream item");
    end
  endtask

  initial
  begin
    seed     = 7;
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    ptr      = '0;
    op_a     = '0;
    op_b     = '0;
    cin_secq = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_reset_state(); // still in reset
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    test_range();
    test_on_low();
    test_max_exp();
    test_clean();
    test_stream();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial
  begin
    #(limit_ns);
    $display("timeout after %0d ns, errors so far: %0d", limit_ns, errors);
    $display("sim failed");
    $finish;
  end

endmodule

// File: src.f
hw/agusec_pkg.sv
hw/agusec_shift8.sv
hw/agusec_check_upper.sv
hw/agusec_range.sv
hw/agusec_unit.sv
dv/agusec_sva.sv
dv/agusec_tb.sv

// File: Bender.yml
package:
  name: agusec

sources:
  - files:
      - hw/agusec_pkg.sv
      - hw/agusec_shift8.sv
      - hw/agusec_check_upper.sv
      - hw/agusec_range.sv
      - hw/agusec_unit.sv
  - target: test
    files:
      - dv/agusec_sva.sv
      - dv/agusec_tb.sv
